// ==== source/mcd212_pkg.sv ====
//********************
// MCD212 address map, register addresses, widths
// and the shared bus, SDRAM and register types
//********************
`default_nettype none

package mcd212_pkg;

    // CPU byte address width
    localparam int CPU_ADDR_W = 23;

    // Memory map of the CPU side, byte addresses
    localparam logic [CPU_ADDR_W-1:0] RAM_TOP    = 23'h3fffff;
    localparam logic [CPU_ADDR_W-1:0] ROM_BASE   = 23'h400000;
    localparam logic [CPU_ADDR_W-1:0] ROM_TOP    = 23'h4ffbff;
    localparam logic [CPU_ADDR_W-1:0] SYSIO_BASE = 23'h4ffc00;
    localparam logic [CPU_ADDR_W-1:0] SYSIO_TOP  = 23'h4fffdf;
    localparam logic [CPU_ADDR_W-1:0] CH2_BASE   = 23'h4fffe0;
    localparam logic [CPU_ADDR_W-1:0] CH2_TOP    = 23'h4fffef;
    localparam logic [CPU_ADDR_W-1:0] CH1_BASE   = 23'h4ffff0;
    localparam logic [CPU_ADDR_W-1:0] CH1_TOP    = 23'h4fffff;

    // Low address byte of the channel 1 status register
    localparam logic [7:0] CH1_STATUS_OFFSET = 8'hf0;

    // Upper strobe accesses that go to ROM after reset
    localparam int BOOT_ROM_CYCLES = 11;

    // Display register addresses
    localparam logic [6:0] CLUT_LAST_ADR = 7'h3f;
    localparam logic [6:0] CLUT_BANK_ADR = 7'h43;

    localparam int COLOUR_W = 6;
    localparam int PIXEL_W  = 8;

    // CPU request, held until acknowledged
    typedef struct packed {
        logic [22:1] addr;
        logic [15:0] din;
        logic        uds;
        logic        lds;
        logic        write_strobe;
        logic        cs;
    } cpu_bus_req_t;

    // Request towards the external SDRAM controller
    typedef struct packed {
        logic [24:0] addr;
        logic        rd;
        logic        wr;
        logic        word;
        logic [15:0] din;
    } sdram_req_t;

    typedef struct packed {
        logic [COLOUR_W-1:0] r;
        logic [COLOUR_W-1:0] g;
        logic [COLOUR_W-1:0] b;
    } clut_entry_t;

    // Colour as carried in a register word, upper 6 bits of each byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } register_colour_t;

    typedef union packed {
        register_colour_t colour_view;
        logic [23:0]      raw;
    } register_word_u;

    // One-cycle display register write, as produced by the ICA
    typedef struct packed {
        logic           write;
        logic [6:0]     adr;
        register_word_u data;
    } display_reg_write_t;

endpackage

`default_nettype wire

// ==== source/memory_map_decoder.sv ====
//********************
// CPU memory map decoder with boot ROM window,
// SDRAM request, read data and bus acknowledge
//********************
`timescale 1ns/10ps
`default_nettype none

module memory_map_decoder (
    input  wire                       clk,
    input  wire                       reset,
    input  mcd212_pkg::cpu_bus_req_t  cpu,
    input  wire                       vblank,
    input  wire [15:0]                sdram_dout,
    input  wire                       sdram_busy,
    output mcd212_pkg::sdram_req_t    sdram,
    output logic [15:0]               cpu_dout,
    output logic                      cpu_bus_ack,
    output logic                      csrom
);

    logic [mcd212_pkg::CPU_ADDR_W-1:0] cpu_addressb;
    logic [3:0]  boot_cnt;
    logic        boot_window;
    logic        cs_ram;
    logic        cs_rom;
    logic        cs_channel1;
    logic [19:1] ram_address;
    logic        ram_access;
    logic        ram_access_q;

    // Byte address as seen by the map
    assign cpu_addressb = {cpu.addr, 1'b0};

    // After reset the first upper strobe accesses are swapped to ROM
    // so the CPU fetches its reset vectors from there
    assign boot_window = boot_cnt < 4'(mcd212_pkg::BOOT_ROM_CYCLES);

    always_ff @(posedge clk) begin
        if (reset) begin
            boot_cnt <= '0;
        end else if (cpu.cs && cpu.uds && boot_window) begin
            boot_cnt <= boot_cnt + 4'd1;
        end
    end

    // Chip selects
    assign cs_ram = cpu.cs && !boot_window && (cpu_addressb <= mcd212_pkg::RAM_TOP);

    assign cs_rom = cpu.cs
                    && (cpu_addressb >= mcd212_pkg::ROM_BASE)
                    && (cpu_addressb <= mcd212_pkg::ROM_TOP);

    assign cs_channel1 = cpu.cs
                         && (cpu_addressb >= mcd212_pkg::CH1_BASE)
                         && (cpu_addressb <= mcd212_pkg::CH1_TOP);

    assign csrom = cpu.cs && (cs_rom || boot_window);

    // Bank select on bit 18 comes first, then bit 21 above the row/column bits
    assign ram_address = {cpu.addr[18], cpu.addr[21], cpu.addr[17:1]};

    always_comb begin
        sdram.addr = {5'b0, ram_address, 1'b0};
        // Odd byte only
        sdram.addr[0] = cpu.lds && !cpu.uds;
        sdram.word    = cpu.lds && cpu.uds;
        sdram.rd      = cs_ram && !cpu.write_strobe;
        sdram.wr      = cs_ram && cpu.write_strobe;
        sdram.din     = cpu.din;
    end

    // First cycle of a RAM access
    // The SDRAM controller holds the rest of the access with busy
    assign ram_access = cs_ram && (cpu.uds || cpu.lds) && !ram_access_q;

    // Set while a RAM access waits for its acknowledge
    always_ff @(posedge clk) begin
        if (reset) begin
            ram_access_q <= 1'b0;
        end else begin
            ram_access_q <= cs_ram && (cpu.uds || cpu.lds) && !cpu_bus_ack;
        end
    end

    assign cpu_bus_ack = !(ram_access || sdram_busy);

    // Read data
    always_comb begin
        cpu_dout = 16'h0;
        if (cs_ram) begin
            cpu_dout = sdram_dout;
        end else if (cs_channel1) begin
            if (!cpu.write_strobe
                && cpu_addressb[7:0] == mcd212_pkg::CH1_STATUS_OFFSET) begin
                // Display active in bit 7 and parity as zero
                cpu_dout = {8'h0, !vblank, 7'b0};
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/clut_palette.sv ====
//********************
// CLUT bank register, colour table
// and the registered pixel to RGB stage
//********************
`timescale 1ns/10ps
`default_nettype none

module clut_palette (
    input  wire                                 clk,
    input  wire                                 reset,
    input  mcd212_pkg::display_reg_write_t      reg_write,
    input  wire [mcd212_pkg::PIXEL_W-1:0]       pixel,
    input  wire                                 pixel_valid,
    input  wire                                 new_line,
    output logic [7:0]                          r,
    output logic [7:0]                          g,
    output logic [7:0]                          b
);

    localparam int PAD_W = 8 - mcd212_pkg::COLOUR_W;

    mcd212_pkg::clut_entry_t clut [256];
    mcd212_pkg::clut_entry_t clut_wdata;
    mcd212_pkg::clut_entry_t clut_out;

    logic [1:0]                     clut_bank;
    logic [mcd212_pkg::PIXEL_W-1:0] clut_wadr;
    logic                           clut_we;
    logic [mcd212_pkg::PIXEL_W-1:0] pixel_hold;

    // Bank register
    always_ff @(posedge clk) begin
        if (reset) begin
            clut_bank <= 2'b00;
        end else if (reg_write.write && reg_write.adr == mcd212_pkg::CLUT_BANK_ADR) begin
            clut_bank <= reg_write.data.raw[1:0];
        end
    end

    // Registers 0 to 63 write a colour into the selected bank
    assign clut_we   = reg_write.write && (reg_write.adr <= mcd212_pkg::CLUT_LAST_ADR);
    assign clut_wadr = {clut_bank, reg_write.adr[5:0]};

    always_comb begin
        clut_wdata.r = reg_write.data.colour_view.r[7 -: mcd212_pkg::COLOUR_W];
        clut_wdata.g = reg_write.data.colour_view.g[7 -: mcd212_pkg::COLOUR_W];
        clut_wdata.b = reg_write.data.colour_view.b[7 -: mcd212_pkg::COLOUR_W];
    end

    always_ff @(posedge clk) begin
        if (clut_we) begin
            clut[clut_wadr] <= clut_wdata;
        end
    end

    // Current pixel, back to index 0 at the start of every line
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_hold <= '0;
        end else if (new_line) begin
            pixel_hold <= '0;
        end else if (pixel_valid) begin
            pixel_hold <= pixel;
        end
    end

    // Look-up is registered, so colour follows the hold register by one clock
    always_ff @(posedge clk) begin
        if (reset) begin
            clut_out <= '0;
        end else begin
            clut_out <= clut[pixel_hold];
        end
    end

    assign r = {clut_out.r, {PAD_W{1'b0}}};
    assign g = {clut_out.g, {PAD_W{1'b0}}};
    assign b = {clut_out.b, {PAD_W{1'b0}}};

endmodule

`default_nettype wire

// ==== source/mcd212.sv ====
//********************
// MCD212 top level, CPU side decoder
// and palette stage
//********************
`timescale 1ns/10ps
`default_nettype none

module mcd212 (
    input  wire                                 clk,
    input  wire                                 reset,

    // CPU bus
    input  mcd212_pkg::cpu_bus_req_t            cpu,
    output logic [15:0]                         cpu_dout,
    output logic                                cpu_bus_ack,
    output logic                                csrom,

    // From video timing
    input  wire                                 vblank,

    // SDRAM controller
    output mcd212_pkg::sdram_req_t              sdram,
    input  wire [15:0]                          sdram_dout,
    input  wire                                 sdram_busy,

    // Display register writes and pixel stream
    input  mcd212_pkg::display_reg_write_t      reg_write,
    input  wire [mcd212_pkg::PIXEL_W-1:0]       pixel,
    input  wire                                 pixel_valid,
    input  wire                                 new_line,

    output logic [7:0]                          r,
    output logic [7:0]                          g,
    output logic [7:0]                          b
);

    memory_map_decoder memory_map_decoder_inst (
        .clk         (clk),
        .reset       (reset),
        .cpu         (cpu),
        .vblank      (vblank),
        .sdram_dout  (sdram_dout),
        .sdram_busy  (sdram_busy),
        .sdram       (sdram),
        .cpu_dout    (cpu_dout),
        .cpu_bus_ack (cpu_bus_ack),
        .csrom       (csrom)
    );

    clut_palette clut_palette_inst (
        .clk         (clk),
        .reset       (reset),
        .reg_write   (reg_write),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .new_line    (new_line),
        .r           (r),
        .g           (g),
        .b           (b)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
//********************
// Testbench clock and reset
//********************
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = !clk;
    end

    // Reset held for five rising edges
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/mcd212_checker.sv ====
//********************
// Reference model of the decoder and palette,
// output comparison and result lines
//********************
`timescale 1ns/10ps
`default_nettype none

module mcd212_checker (
    input  wire                              clk,
    input  wire                              reset,
    input  mcd212_pkg::cpu_bus_req_t         cpu,
    input  wire                              vblank,
    input  mcd212_pkg::sdram_req_t           sdram,
    input  wire [15:0]                       sdram_dout,
    input  wire                              sdram_busy,
    input  wire [15:0]                       cpu_dout,
    input  wire                              cpu_bus_ack,
    input  wire                              csrom,
    input  mcd212_pkg::display_reg_write_t   reg_write,
    input  wire [7:0]                        pixel,
    input  wire                              pixel_valid,
    input  wire                              new_line,
    input  wire [7:0]                        r,
    input  wire [7:0]                        g,
    input  wire [7:0]                        b,
    input  wire [2:0]                        test_id,
    input  wire                              test_end,
    input  wire                              run_end,
    output int                               error_count
);

    int          boot_m;
    logic        prev_m;
    logic [1:0]  bank_m;
    logic [7:0]  hold_m;
    logic [17:0] out_m;
    logic        out_known;
    logic [17:0] clut_m [256];
    logic        clut_set [256];
    int          test_checks = 0;
    int          test_errors = 0;
    int          total_checks = 0;
    int          total_errors = 0;

    assign error_count = total_errors;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1: return "boot window";
            3'd2: return "memory map";
            3'd3: return "ram requests";
            3'd4: return "acknowledge";
            3'd5: return "channel 1 status";
            3'd6: return "palette";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        test_checks++;
        total_checks++;
        if (actual !== expected) begin
            $display("ERR %s at %0t: expected %h, actual %h", name, $time, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic step_cpu_model();
        logic [22:0] adr_b;
        logic        boot;
        logic        ram_sel;
        logic        ram_first;
        logic        ack_exp;
        logic        status_rd;
        logic [15:0] dout_exp;
        adr_b     = {cpu.addr, 1'b0};
        boot      = boot_m < mcd212_pkg::BOOT_ROM_CYCLES;
        ram_sel   = cpu.cs && !boot && (adr_b <= mcd212_pkg::RAM_TOP);
        ram_first = ram_sel && (cpu.uds || cpu.lds) && !prev_m;
        ack_exp   = !(ram_first || sdram_busy);
        status_rd = cpu.cs && !cpu.write_strobe && (adr_b >= mcd212_pkg::CH1_BASE)
                    && (adr_b <= mcd212_pkg::CH1_TOP)
                    && (adr_b[7:0] == mcd212_pkg::CH1_STATUS_OFFSET);
        dout_exp  = ram_sel ? sdram_dout : (status_rd ? {8'h00, !vblank, 7'h00} : 16'h0000);
        if (!reset) begin
            compare("csrom", 32'(csrom), 32'(cpu.cs && (boot
                    || (adr_b >= mcd212_pkg::ROM_BASE && adr_b <= mcd212_pkg::ROM_TOP))));
            compare("sdram.rd", 32'(sdram.rd), 32'(ram_sel && !cpu.write_strobe));
            compare("sdram.wr", 32'(sdram.wr), 32'(ram_sel && cpu.write_strobe));
            compare("sdram.addr", 32'(sdram.addr), 32'({5'b0, cpu.addr[18], cpu.addr[21],
                    cpu.addr[17:1], cpu.lds && !cpu.uds}));
            compare("sdram.word", 32'(sdram.word), 32'(cpu.uds && cpu.lds));
            compare("sdram.din", 32'(sdram.din), 32'(cpu.din));
            compare("cpu_dout", 32'(cpu_dout), 32'(dout_exp));
            compare("cpu_bus_ack", 32'(cpu_bus_ack), 32'(ack_exp));
        end
        if (reset) begin
            boot_m = 0;
            prev_m = 1'b0;
        end else begin
            if (cpu.cs && cpu.uds && boot) begin
                boot_m++;
            end
            // RAM access still waiting for its acknowledge
            prev_m = ram_sel && (cpu.uds || cpu.lds) && !ack_exp;
        end
    endtask

    task automatic step_palette_model();
        logic [7:0] wadr;
        if (!reset && out_known) begin
            compare("r", 32'(r), 32'({out_m[17:12], 2'b00}));
            compare("g", 32'(g), 32'({out_m[11:6], 2'b00}));
            compare("b", 32'(b), 32'({out_m[5:0], 2'b00}));
        end
        if (reset) begin
            bank_m    = 2'b00;
            hold_m    = 8'h00;
            out_m     = 18'h0;
            out_known = 1'b1;
            for (int i = 0; i < 256; i++) begin
                clut_set[i] = 1'b0;
            end
        end else begin
            // Output takes the entry before this edge's table write
            out_m     = clut_m[hold_m];
            out_known = clut_set[hold_m];
            wadr      = {bank_m, reg_write.adr[5:0]};
            if (reg_write.write && reg_write.adr <= mcd212_pkg::CLUT_LAST_ADR) begin
                clut_m[wadr]   = {reg_write.data.raw[23:18], reg_write.data.raw[15:10],
                                  reg_write.data.raw[7:2]};
                clut_set[wadr] = 1'b1;
            end
            if (reg_write.write && reg_write.adr == mcd212_pkg::CLUT_BANK_ADR) begin
                bank_m = reg_write.data.raw[1:0];
            end
            if (new_line) begin
                hold_m = 8'h00;
            end else if (pixel_valid) begin
                hold_m = pixel;
            end
        end
    endtask

    // Inputs change on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        step_cpu_model();
        step_palette_model();
        if (test_end) begin
            $display("test %0d %s done: %0d checks, %0d errors",
                     test_id, test_name(test_id), test_checks, test_errors);
            test_checks = 0;
            test_errors = 0;
        end
        if (run_end) begin
            $display("total: %0d checks, %0d errors", total_checks, total_errors);
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_mcd212.sv ====
//********************
// Testbench top with DUT, stimulus
// and SDRAM responder
//********************
`timescale 1ns/10ps
`default_nettype none

module tb_mcd212;

    localparam int ACK_TIMEOUT   = 64;
    localparam int RESET_TIMEOUT = 20;

    logic                              clk;
    logic                              reset;
    mcd212_pkg::cpu_bus_req_t          cpu;
    logic [15:0]                       cpu_dout;
    logic                              cpu_bus_ack;
    logic                              csrom;
    logic                              vblank;
    mcd212_pkg::sdram_req_t            sdram;
    logic [15:0]                       sdram_dout;
    logic                              sdram_busy;
    mcd212_pkg::display_reg_write_t    reg_write;
    logic [7:0]                        pixel;
    logic                              pixel_valid;
    logic                              new_line;
    logic [7:0]                        r;
    logic [7:0]                        g;
    logic [7:0]                        b;
    logic [2:0]                        test_id;
    logic                              test_end;
    logic                              run_end;
    logic                              timed_out;
    int                                error_count;
    int                                seed = 32'h9568;

    tb_clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    mcd212 mcd212_inst (
        .clk (clk), .reset (reset), .cpu (cpu), .cpu_dout (cpu_dout),
        .cpu_bus_ack (cpu_bus_ack), .csrom (csrom), .vblank (vblank), .sdram (sdram),
        .sdram_dout (sdram_dout), .sdram_busy (sdram_busy), .reg_write (reg_write),
        .pixel (pixel), .pixel_valid (pixel_valid), .new_line (new_line),
        .r (r), .g (g), .b (b)
    );

    mcd212_checker checker_inst (
        .clk (clk), .reset (reset), .cpu (cpu), .vblank (vblank), .sdram (sdram),
        .sdram_dout (sdram_dout), .sdram_busy (sdram_busy), .cpu_dout (cpu_dout),
        .cpu_bus_ack (cpu_bus_ack), .csrom (csrom), .reg_write (reg_write),
        .pixel (pixel), .pixel_valid (pixel_valid), .new_line (new_line),
        .r (r), .g (g), .b (b), .test_id (test_id), .test_end (test_end),
        .run_end (run_end), .error_count (error_count)
    );

    // SDRAM responder with random data and random busy cycles
    initial begin
        sdram_dout = 16'h0000;
        sdram_busy = 1'b0;
        forever begin
            @(posedge clk);
            sdram_dout <= 16'($urandom);
            sdram_busy <= ($urandom % 4) == 0;
        end
    end

    // 0 RAM, 1 upper megabyte, 2 system I/O and channels, 3 channels,
    // 4 channel 1 status, otherwise anywhere
    function automatic logic [22:1] random_address(input int kind);
        case (kind)
            0: return {1'b0, 21'($urandom)};
            1: return {3'b100, 19'($urandom)};
            2: return {13'h13ff, 9'($urandom)};
            3: return {18'h27fff, 4'($urandom)};
            4: return 22'h27fff8;
            default: return 22'($urandom);
        endcase
    endfunction

    task automatic bus_access(input logic [22:1] adr, input logic we, input logic [1:0] strobes);
        int waited;
        if (!timed_out) begin
            cpu.addr         <= adr;
            cpu.din          <= 16'($urandom);
            cpu.uds          <= strobes[1];
            cpu.lds          <= strobes[0];
            cpu.write_strobe <= we;
            cpu.cs           <= 1'b1;
            vblank           <= 1'($urandom);
            waited = 0;
            @(negedge clk);
            while (!cpu_bus_ack && waited < ACK_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!cpu_bus_ack) begin
                $display("timeout: no bus acknowledge for byte address %h", {adr, 1'b0});
                timed_out = 1'b1;
            end
            @(posedge clk);
            cpu.cs <= 1'b0;
        end
    endtask

    task automatic write_register(input logic [6:0] adr, input logic [23:0] data);
        reg_write.write    <= 1'b1;
        reg_write.adr      <= adr;
        reg_write.data.raw <= data;
        @(posedge clk);
        reg_write.write    <= 1'b0;
    endtask

    task automatic end_test();
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    task automatic palette_test();
        for (int bank = 0; bank < 4; bank++) begin
            write_register(mcd212_pkg::CLUT_BANK_ADR, 24'(bank));
            for (int idx = 0; idx < 64; idx++) begin
                write_register(7'(idx), 24'($urandom));
            end
        end
        for (int n = 0; n < 300; n++) begin
            pixel       <= 8'($urandom);
            pixel_valid <= ($urandom % 2) == 0;
            new_line    <= ($urandom % 16) == 0;
            @(posedge clk);
        end
        pixel_valid <= 1'b0;
        new_line    <= 1'b0;
        // Colour appears two edges after the last pixel
        repeat (3) @(posedge clk);
    endtask

    initial begin
        int waited;
        void'($urandom(seed));
        cpu = '0;
        vblank = 1'b0;
        reg_write = '0;
        pixel = 8'h00;
        pixel_valid = 1'b0;
        new_line = 1'b0;
        test_id = 3'd0;
        test_end = 1'b0;
        run_end = 1'b0;
        timed_out = 1'b0;
        waited = 0;
        @(posedge clk);
        while (reset && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (reset) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end

        test_id <= 3'd1;
        for (int n = 0; n < mcd212_pkg::BOOT_ROM_CYCLES; n++) begin
            bus_access(random_address(5), 1'($urandom), {1'b1, 1'($urandom)});
        end
        for (int n = 0; n < 8; n++) begin
            bus_access(random_address(0), 1'($urandom), 2'b11);
        end
        end_test();

        test_id <= 3'd2;
        for (int n = 0; n < 40; n++) begin
            bus_access(random_address(int'($urandom % 6)), 1'($urandom), 2'($urandom % 3 + 1));
        end
        end_test();

        test_id <= 3'd3;
        for (int n = 0; n < 40; n++) begin
            bus_access(random_address(0), 1'($urandom), 2'($urandom % 3 + 1));
        end
        end_test();

        // Random idle cycles between accesses
        test_id <= 3'd4;
        for (int n = 0; n < 40; n++) begin
            bus_access(random_address(int'($urandom % 6)), 1'($urandom), 2'($urandom % 3 + 1));
            if ($urandom % 3 == 0) begin
                @(posedge clk);
            end
        end
        end_test();

        test_id <= 3'd5;
        for (int n = 0; n < 24; n++) begin
            bus_access(random_address((n % 2 == 0) ? 4 : 3), 1'b0, 2'b11);
        end
        end_test();

        test_id <= 3'd6;
        palette_test();
        end_test();

        run_end <= 1'b1;
        @(negedge clk);
        @(posedge clk);
        if (timed_out || error_count != 0) begin
            $display("Test FAILED");
        end else begin
            $display("Test OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mcd212.f ====
source/mcd212_pkg.sv
source/memory_map_decoder.sv
source/clut_palette.sv
source/mcd212.sv
sim/tb_clock_gen.sv
sim/mcd212_checker.sv
sim/tb_mcd212.sv

// ==== Makefile ====
SOURCES := $(filter-out +%,$(shell cat mcd212.f))

.PHONY: run clean

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_mcd212: mcd212.f $(SOURCES)
	verilator --binary --timing -f mcd212.f --top-module tb_mcd212 -Mdir obj_dir

run: obj_dir/Vtb_mcd212
	./obj_dir/Vtb_mcd212 > sim.log
	cat sim.log
	grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
